//--- compile.f
rtl/stream_pkg.sv
rtl/net_pkg.sv
rtl/stream_ifs.sv
rtl/adc_sample_fifo.sv
rtl/udp_frame_builder.sv
rtl/gmii_byte_serializer.sv
rtl/eth_adc_streamer_top.sv
verif/eth_adc_sva.sv
verif/eth_adc_tb.sv

//--- verif/eth_adc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module eth_adc_tb;
	import stream_pkg::*;
	import net_pkg::*;

	localparam int NUM_ROWS     = 5;
	localparam int FRAME_BYTES  = 76;
	localparam int SEQ_POS      = 42;  // Bytes before the sequence number
	localparam int PAY_POS      = 44;
	localparam int FRAME_BUDGET = 100; // Cycles per expected frame
	localparam int MAX_FRAMES   = 16;
	localparam int MAX_BYTES    = 128;

	typedef struct {
		string name;
		int    samples;
		int    spacing;  // Clocks from one write to the next
		bit    ovf;
		int    frames;
	} row_t;

	logic                GMII_GTX_CLK_int;
	logic                wb_rst;
	logic                sample_we_i;
	logic [SAMPLE_W-1:0] sample_a_i;
	logic [SAMPLE_W-1:0] sample_b_i;
	logic [7:0]          gmii_txd_o;
	logic                gmii_tx_en_o;
	logic                gmii_tx_er_o;
	logic                fifo_overflow_o;

	row_t              tbl [NUM_ROWS];
	logic [WORD_W-1:0] model_q [$];  // Written samples with B in the upper half
	logic [7:0]        exp_hdr [SEQ_POS];
	logic [7:0]        cap_bytes [MAX_FRAMES][MAX_BYTES];
	int                cap_len [MAX_FRAMES];
	int                frames_done = 0;
	int                cur_len = 0;
	int                hdr_len = 0;
	int                err_cnt = 0;
	int                tests_run = 0;
	int                tests_failed = 0;
	int                cycle_cnt = 0;
	int                timeout_limit = 0;
	int                exp_seq = 0;
	integer            seed = 94;

	eth_adc_streamer_top dut (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.sample_we_i      (sample_we_i),
		.sample_a_i       (sample_a_i),
		.sample_b_i       (sample_b_i),
		.gmii_txd_o       (gmii_txd_o),
		.gmii_tx_en_o     (gmii_tx_en_o),
		.gmii_tx_er_o     (gmii_tx_er_o),
		.fifo_overflow_o  (fifo_overflow_o)
	);

	initial GMII_GTX_CLK_int = 1'b0;
	always #10 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

	always @(posedge GMII_GTX_CLK_int) begin
		cycle_cnt = cycle_cnt + 1;
		if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
			$display("Timeout: expected frames missing after %0d cycles", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	// Frame capture mid-cycle where TXD is stable
	always @(negedge GMII_GTX_CLK_int) begin
		if (gmii_tx_en_o) begin
			if (cur_len < MAX_BYTES && frames_done < MAX_FRAMES) begin
				cap_bytes[frames_done][cur_len] = gmii_txd_o;
			end
			cur_len++;
		end else if (cur_len != 0) begin
			if (frames_done < MAX_FRAMES) begin
				cap_len[frames_done] = cur_len;
			end
			frames_done++;
			cur_len = 0;
		end
	end

	//////////////////////////////////////////////////////////////
	// Checks and expected frame contents
	//////////////////////////////////////////////////////////////
	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic add_field(input logic [47:0] val, input int nbytes);
		int i;
		for (i = nbytes - 1; i >= 0; i--) begin
			exp_hdr[hdr_len] = val[i*8 +: 8]; // MSB first
			hdr_len++;
		end
	endtask

	task automatic build_header();
		logic [31:0] sum;
		int i;
		hdr_len = 0;
		add_field(DST_MAC, 6);
		add_field(MY_MAC, 6);
		add_field(16'h0800, 2);
		add_field(8'h45, 1);
		add_field(8'h00, 1);
		add_field(IP_TOTAL_LEN, 2);
		add_field(32'h0000_0000, 4);  // ID and flags
		add_field(8'd64, 1);
		add_field(8'd17, 1);
		add_field(16'h0000, 2);       // Checksum filled in below
		add_field(MY_IP, 4);
		add_field(DST_IP, 4);
		add_field(UDP_SRC_PORT, 2);
		add_field(UDP_DST_PORT, 2);
		add_field(UDP_LEN, 2);
		add_field(16'h0000, 2);
		// One's complement sum over the 20 IP header bytes
		sum = 0;
		for (i = 14; i < 34; i += 2) begin
			sum += {exp_hdr[i], exp_hdr[i+1]};
		end
		sum = sum[31:16] + sum[15:0];
		sum = sum[31:16] + sum[15:0];
		{exp_hdr[24], exp_hdr[25]} = ~sum[15:0];
	endtask

	task automatic match_in_order(input string test, input logic [31:0] actual);
		while (model_q.size() > 0 && model_q[0] !== actual) begin
			void'(model_q.pop_front()); // Dropped by the full FIFO
		end
		if (model_q.size() == 0) begin
			$display("%s: payload word %h is not among the remaining written samples",
				test, actual);
			err_cnt++;
		end else begin
			void'(model_q.pop_front());
		end
	endtask

	task automatic check_frame(input int idx, input string test, input bit ovf_row);
		logic [31:0] act;
		int i;
		check_value(test, "frame length", FRAME_BYTES, cap_len[idx]);
		if (cap_len[idx] == FRAME_BYTES) begin
			for (i = 0; i < SEQ_POS; i++) begin
				check_value(test, $sformatf("header byte %0d", i), exp_hdr[i],
					cap_bytes[idx][i]);
			end
			check_value(test, "sequence", exp_seq,
				{cap_bytes[idx][SEQ_POS], cap_bytes[idx][SEQ_POS+1]});
			for (i = 0; i < PAYLOAD_WORDS; i++) begin
				act = {cap_bytes[idx][PAY_POS+4*i], cap_bytes[idx][PAY_POS+4*i+1],
					cap_bytes[idx][PAY_POS+4*i+2], cap_bytes[idx][PAY_POS+4*i+3]};
				if (ovf_row) begin
					match_in_order(test, act);
				end else if (model_q.size() == 0) begin
					$display("%s: frame carries more payload than was written", test);
					err_cnt++;
				end else begin
					check_value(test, $sformatf("payload word %0d", i),
						model_q.pop_front(), act);
				end
			end
		end
		exp_seq++;
	endtask

	//////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////
	task automatic load_table();
		tbl[0] = '{"single_packet", 8, 3, 1'b0, 1};
		tbl[1] = '{"two_packets", 16, 2, 1'b0, 2};
		tbl[2] = '{"short_burst", 5, 2, 1'b0, 0};     // Below one packet
		tbl[3] = '{"fill_remainder", 11, 4, 1'b0, 2}; // Joins the 5 still stored
		// Burst ends before the first header is out, so one full FIFO is sent
		tbl[4] = '{"overflow_burst", 40, 1, 1'b1, 2};
	endtask

	function automatic int run_budget();
		int r;
		int total;
		total = 20;
		for (r = 0; r < NUM_ROWS; r++) begin
			total += tbl[r].samples * tbl[r].spacing + 10;
			total += FRAME_BUDGET * ((tbl[r].frames > 0) ? tbl[r].frames : 1);
		end
		return total;
	endfunction

	task automatic write_samples(input int n, input int spacing);
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		int i;
		int k;
		for (i = 0; i < n; i++) begin
			@(posedge GMII_GTX_CLK_int);
			#1;
			rnd_a = $random(seed);
			rnd_b = $random(seed);
			sample_we_i = 1'b1;
			sample_a_i  = rnd_a[15:0];
			sample_b_i  = rnd_b[15:0];
			model_q.push_back({rnd_b[15:0], rnd_a[15:0]});
			for (k = 1; k < spacing; k++) begin
				@(posedge GMII_GTX_CLK_int);
				#1;
				sample_we_i = 1'b0;
			end
		end
		@(posedge GMII_GTX_CLK_int);
		#1;
		sample_we_i = 1'b0;
	endtask

	task automatic finish_test(input string test, input int errs_before);
		tests_run++;
		if (err_cnt != errs_before) begin
			tests_failed++;
		end
		$display("%-16s done, %0d mismatches", test, err_cnt - errs_before);
	endtask

	task automatic run_row(input int r);
		int frames_before;
		int errs_before;
		int i;
		frames_before = frames_done;
		errs_before   = err_cnt;
		write_samples(tbl[r].samples, tbl[r].spacing);
		if (tbl[r].frames == 0) begin
			repeat (FRAME_BUDGET) @(posedge GMII_GTX_CLK_int);
			check_value(tbl[r].name, "frames", 0, frames_done - frames_before);
			check_value(tbl[r].name, "bytes in flight", 0, cur_len);
		end else begin
			while (frames_done < frames_before + tbl[r].frames) begin
				@(posedge GMII_GTX_CLK_int);
			end
			for (i = 0; i < tbl[r].frames; i++) begin
				check_frame(frames_before + i, tbl[r].name, tbl[r].ovf);
			end
		end
		check_value(tbl[r].name, "overflow flag", tbl[r].ovf, fifo_overflow_o);
		finish_test(tbl[r].name, errs_before);
	endtask

	initial begin
		int r;
		int sva_fails;
		sample_we_i = 1'b0;
		sample_a_i  = '0;
		sample_b_i  = '0;
		wb_rst      = 1'b1;
		load_table();
		build_header();
		timeout_limit = run_budget();
		repeat (2) @(posedge GMII_GTX_CLK_int);
		#1;
		wb_rst = 1'b0;
		@(posedge GMII_GTX_CLK_int);
		#1;
		r = err_cnt;
		check_value("reset_state", "TX_EN", 0, gmii_tx_en_o);
		check_value("reset_state", "TX_ER", 0, gmii_tx_er_o);
		check_value("reset_state", "TXD", 0, gmii_txd_o);
		check_value("reset_state", "overflow flag", 0, fifo_overflow_o);
		finish_test("reset_state", r);
		for (r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end
		sva_fails = dut.u_serializer.u_sva.fail_cnt + dut.u_fifo.u_sva.fail_cnt;
		$display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
			tests_run, tests_failed, err_cnt, sva_fails);
		if (tests_failed == 0 && err_cnt == 0 && sva_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/eth_adc_sva.sv
`timescale 1ns/1ns
`default_nettype none

module eth_adc_sva (
	input logic GMII_GTX_CLK_int,
	input logic wb_rst,
	input logic tx_en_i,
	input logic tx_er_i,
	input logic pop_i,
	input logic empty_i
);
	import stream_pkg::*;

	int fail_cnt = 0;

	// TX_ER has no source in this design
	tx_er_low: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst) !tx_er_i)
	else begin
		$error("TX_ER went high");
		fail_cnt++;
	end

	no_pop_empty: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst)
		!(pop_i && empty_i))
	else begin
		$error("Pop issued while the sample FIFO is empty");
		fail_cnt++;
	end

	// Idle gap after every frame
	ifg_hold: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst)
		$fell(tx_en_i) |-> !tx_en_i [*IFG_CYCLES])
	else begin
		$error("TX_EN rose again before the inter-frame gap ended");
		fail_cnt++;
	end

endmodule

bind gmii_byte_serializer eth_adc_sva u_sva (
	.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
	.wb_rst           (wb_rst),
	.tx_en_i          (gmii_tx_en_o),
	.tx_er_i          (gmii_tx_er_o),
	.pop_i            (1'b0),
	.empty_i          (1'b0)
);

bind adc_sample_fifo eth_adc_sva u_sva (
	.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
	.wb_rst           (wb_rst),
	.tx_en_i          (1'b0),
	.tx_er_i          (1'b0),
	.pop_i            (rd.pop),
	.empty_i          (rd.empty)
);

`default_nettype wire

//--- rtl/eth_adc_streamer_top.sv
`timescale 1ns/1ns
`default_nettype none

module eth_adc_streamer_top (
	input  logic                            GMII_GTX_CLK_int,
	input  logic                            wb_rst,
	input  logic                            sample_we_i,
	input  logic [stream_pkg::SAMPLE_W-1:0] sample_a_i,
	input  logic [stream_pkg::SAMPLE_W-1:0] sample_b_i,
	output logic [7:0]                      gmii_txd_o,
	output logic                            gmii_tx_en_o,
	output logic                            gmii_tx_er_o,
	output logic                            fifo_overflow_o
);

	sample_rd_if  rd_bus ();
	frame_word_if fw_bus ();

	////////////////////////////////////////////////////////////
	// Sample buffer, frame builder, byte serializer
	////////////////////////////////////////////////////////////
	adc_sample_fifo u_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.sample_we_i      (sample_we_i),
		.sample_a_i       (sample_a_i),
		.sample_b_i       (sample_b_i),
		.rd               (rd_bus.fifo),
		.fifo_overflow_o  (fifo_overflow_o)
	);

	udp_frame_builder u_builder (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.rd               (rd_bus.builder),
		.wr               (fw_bus.builder)
	);

	// Drives the registered GMII pins directly
	gmii_byte_serializer u_serializer (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.wr               (fw_bus.serializer),
		.gmii_txd_o       (gmii_txd_o),
		.gmii_tx_en_o     (gmii_tx_en_o),
		.gmii_tx_er_o     (gmii_tx_er_o)
	);

endmodule

`default_nettype wire

//--- rtl/gmii_byte_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module gmii_byte_serializer (
	input  logic               GMII_GTX_CLK_int,
	input  logic               wb_rst,
	frame_word_if.serializer   wr,
	output logic [7:0]         gmii_txd_o,
	output logic               gmii_tx_en_o,
	output logic               gmii_tx_er_o
);
	import stream_pkg::*;

	frame_word_u word_q;
	logic [1:0]  byte_idx;  // Byte currently on TXD
	logic        busy;
	logic        last_q;

	// Next word is accepted while its predecessor's final byte is out,
	// except at the end of a frame where TX_EN must drop
	assign wr.take = wr.valid && (!busy || (byte_idx == 2'd0 && !last_q));

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (wr.take) begin
			word_q <= wr.word;
		end
	end

	////////////////////////////////////////////////////////////
	// GMII transmit registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			busy         <= 1'b0;
			byte_idx     <= 2'd0;
			last_q       <= 1'b0;
			gmii_txd_o   <= 8'h00;
			gmii_tx_en_o <= 1'b0;
			gmii_tx_er_o <= 1'b0;
		end else begin
			gmii_tx_er_o <= 1'b0; // No error signalling
			if (wr.take) begin
				busy         <= 1'b1;
				byte_idx     <= 2'd3;
				last_q       <= wr.last;
				gmii_txd_o   <= wr.word.bytes[3]; // MSB first
				gmii_tx_en_o <= 1'b1;
			end else if (busy && byte_idx != 2'd0) begin
				byte_idx   <= byte_idx - 2'd1;
				gmii_txd_o <= word_q.bytes[byte_idx - 2'd1];
			end else begin
				busy         <= 1'b0;
				last_q       <= 1'b0;
				gmii_txd_o   <= 8'h00;
				gmii_tx_en_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/udp_frame_builder.sv
`timescale 1ns/1ns
`default_nettype none

module udp_frame_builder (
	input  logic           GMII_GTX_CLK_int,
	input  logic           wb_rst,
	sample_rd_if.builder   rd,
	frame_word_if.builder  wr
);
	import stream_pkg::*;
	import net_pkg::*;

	logic [1:0]                        state;
	logic [$clog2(HDR_WORDS)-1:0]      word_idx;
	logic [15:0]                       seq;
	logic [$clog2(IFG_CYCLES+2)-1:0]   gap_cnt;
	logic [WORD_W-1:0]                 hdr_word;
	logic                              gap_done;

	////////////////////////////////////////////////////////////
	// Word source
	////////////////////////////////////////////////////////////
	always_comb begin
		hdr_word = HDR_TABLE[word_idx];
		if (word_idx == HDR_WORDS - 1) begin
			hdr_word[15:0] = seq; // Sequence number closes the header
		end
	end

	always_comb begin
		if (state == ST_PAYLOAD) begin
			wr.word = rd.head;
		end else begin
			wr.word = hdr_word;
		end
	end

	assign wr.valid = (state == ST_HEADER) || (state == ST_PAYLOAD);
	assign wr.last  = (state == ST_PAYLOAD) && (word_idx == PAYLOAD_WORDS - 1);
	assign rd.pop   = (state == ST_PAYLOAD) && wr.take;

	// The last word spends four more cycles on the wire, and idle plus
	// header entry take two, so the wait is stretched to keep the full gap
	assign gap_done = (gap_cnt == IFG_CYCLES + 1);

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			state    <= ST_IDLE;
			word_idx <= '0;
			seq      <= '0;
			gap_cnt  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					word_idx <= '0;
					if (rd.pkt_ready) begin
						state <= ST_HEADER;
					end
				end

				ST_HEADER: begin
					if (wr.take) begin
						if (word_idx == HDR_WORDS - 1) begin
							state    <= ST_PAYLOAD;
							word_idx <= '0;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end

				ST_PAYLOAD: begin
					if (wr.take) begin
						if (wr.last) begin
							state   <= ST_GAP;
							gap_cnt <= '0;
							seq     <= seq + 1'b1;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end

				ST_GAP: begin
					if (gap_done) begin
						state <= ST_IDLE;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/adc_sample_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module adc_sample_fifo (
	input  logic                        GMII_GTX_CLK_int,
	input  logic                        wb_rst,
	input  logic                        sample_we_i,
	input  logic [stream_pkg::SAMPLE_W-1:0] sample_a_i,
	input  logic [stream_pkg::SAMPLE_W-1:0] sample_b_i,
	sample_rd_if.fifo                   rd,
	output logic                        fifo_overflow_o
);
	import stream_pkg::*;

	frame_word_u mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	frame_word_u        wr_word;
	logic               full;
	logic               push;
	logic               pop_ok;

	// Channel B in the upper half
	always_comb begin
		wr_word.pair.chan_b = sample_b_i;
		wr_word.pair.chan_a = sample_a_i;
	end

	assign full   = (count == FIFO_DEPTH);
	assign push   = sample_we_i && !full; // Writes while full are lost
	assign pop_ok = rd.pop && !rd.empty;

	////////////////////////////////////////////////////////////
	// Status and fall-through head
	////////////////////////////////////////////////////////////
	assign rd.empty     = (count == '0);
	assign rd.pkt_ready = (count >= PAYLOAD_WORDS);
	assign rd.head      = mem[rd_ptr];

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (push) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			wr_ptr          <= '0;
			rd_ptr          <= '0;
			count           <= '0;
			fifo_overflow_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// Simultaneous push and pop leave the count alone
			case ({push, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			if (sample_we_i && full) begin
				fifo_overflow_o <= 1'b1; // Sticky until reset
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/stream_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// FIFO head and pop strobe towards the frame builder
interface sample_rd_if;
	import stream_pkg::*;

	frame_word_u head;  // Oldest stored word
	logic pkt_ready;    // At least one packet stored
	logic empty;
	logic pop;

	modport fifo (
		output head, pkt_ready, empty,
		input  pop
	);

	modport builder (
		input  head, pkt_ready, empty,
		output pop
	);
endinterface

// Frame words towards the byte serializer
interface frame_word_if;
	import stream_pkg::*;

	frame_word_u word;
	logic valid;
	logic last;  // Final payload word of a frame
	logic take;  // One-cycle accept from the serializer

	modport builder (
		output word, valid, last,
		input  take
	);

	modport serializer (
		input  word, valid, last,
		output take
	);
endinterface

`default_nettype wire

//--- rtl/net_pkg.sv
`default_nettype none

package net_pkg;

	// Fixed station addresses
	localparam logic [47:0] MY_MAC  = 48'h0037_ffff_3737;
	localparam logic [47:0] DST_MAC = 48'h0090_f5de_6431;
	localparam logic [31:0] MY_IP   = 32'hc0a8_012a; // 192.168.1.42
	localparam logic [31:0] DST_IP  = 32'hc0a8_0101; // 192.168.1.1

	localparam logic [15:0] UDP_SRC_PORT = 16'd5000;
	localparam logic [15:0] UDP_DST_PORT = 16'd5001;

	////////////////////////////////////////////////////////////
	// Header fields
	////////////////////////////////////////////////////////////
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_VER_IHL    = 8'h45;
	localparam logic [7:0]  IP_TTL        = 8'd64;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

	// 20 IP + 8 UDP + 2 sequence + 32 payload bytes
	localparam logic [15:0] IP_TOTAL_LEN = 16'd62;
	localparam logic [15:0] UDP_LEN      = 16'd42;

	// One's complement sum over the header with ID and flags at zero
	localparam logic [31:0] IP_SUM = {IP_VER_IHL, 8'h00} + IP_TOTAL_LEN +
		{IP_TTL, IP_PROTO_UDP} + MY_IP[31:16] + MY_IP[15:0] +
		DST_IP[31:16] + DST_IP[15:0];
	localparam logic [31:0] IP_FOLD = IP_SUM[31:16] + IP_SUM[15:0];
	localparam logic [15:0] IP_HDR_CSUM = ~(IP_FOLD[31:16] + IP_FOLD[15:0]);

	////////////////////////////////////////////////////////////
	// Header word table in wire order
	////////////////////////////////////////////////////////////
	localparam int HDR_WORDS = 11;

	localparam logic [0:HDR_WORDS-1][31:0] HDR_TABLE = {
		DST_MAC, MY_MAC, ETH_TYPE_IPV4,
		IP_VER_IHL, 8'h00, IP_TOTAL_LEN,
		16'h0000, 16'h0000,               // ID, flags and fragment offset
		IP_TTL, IP_PROTO_UDP, IP_HDR_CSUM,
		MY_IP, DST_IP,
		UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN,
		16'h0000,                         // UDP checksum unused
		16'h0000                          // Sequence number slot
	};

endpackage

`default_nettype wire

//--- rtl/stream_pkg.sv
`default_nettype none

package stream_pkg;

	localparam int SAMPLE_W      = 16;
	localparam int WORD_W        = 32;
	localparam int PAYLOAD_WORDS = 8;  // Samples per UDP packet

	// Depth must stay a power of two so pointers wrap freely
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;

	localparam int IFG_CYCLES = 12;    // Idle clocks between frames

	////////////////////////////////////////////////////////////
	// Frame builder states
	////////////////////////////////////////////////////////////
	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_HEADER  = 2'd1;
	localparam logic [1:0] ST_PAYLOAD = 2'd2;
	localparam logic [1:0] ST_GAP     = 2'd3;

	// One word seen as a sample pair or as bytes with byte 3 first on the wire
	typedef union packed {
		struct packed {
			logic [SAMPLE_W-1:0] chan_b;
			logic [SAMPLE_W-1:0] chan_a;
		} pair;
		logic [WORD_W/8-1:0][7:0] bytes;
	} frame_word_u;

endpackage

`default_nettype wire
